/* hdl/uart_pkg.sv */
// UART link package with payload, request, result and state types.
package uart_pkg;

    // ------------------------------------------------------------
    // Payload and client types
    // ------------------------------------------------------------
    typedef logic [7:0] uart_byte_t;

    // One-cycle strobe with its byte.
    typedef struct packed {
        logic       strobe;
        uart_byte_t data;
    } client_req_t;

    // Received byte with its error flags.
    typedef struct packed {
        uart_byte_t data;
        logic       parity_err;
        logic       frame_err;
    } rx_result_t;

    // ------------------------------------------------------------
    // State encodings
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        TX_IDLE   = 3'b001,
        TX_START  = 3'b010,
        TX_DATA   = 3'b011,
        TX_STOP   = 3'b100,
        TX_CLEAN  = 3'b101,
        TX_PARITY = 3'b110
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE   = 3'b001,
        RX_START  = 3'b010,
        RX_DATA   = 3'b011,
        RX_STOP   = 3'b100,
        RX_PARITY = 3'b110
    } rx_state_t;

endpackage

/* hdl/tx_arbiter.sv */
// Round-robin arbiter holding one pending byte per client for the transmitter.
`timescale 1ns/1ps

module tx_arbiter import uart_pkg::*; (
    input  logic        clk,
    input  logic        nRst,
    input  client_req_t req0,
    input  client_req_t req1,
    output logic        busy0,
    output logic        busy1,
    input  logic        transmit_ready,
    output logic        tx_ctrl,
    output uart_byte_t  tx_byte
);
    logic       pend0;
    logic       pend1;
    uart_byte_t byte0;
    uart_byte_t byte1;
    logic       last1;
    logic       sel1;
    logic       grant;

    assign busy0 = pend0;
    assign busy1 = pend1;

    // Both pending: serve the client not served last.
    assign sel1    = (pend0 && pend1) ? !last1 : pend1;
    assign grant   = transmit_ready && (pend0 || pend1);
    assign tx_ctrl = grant;
    assign tx_byte = sel1 ? byte1 : byte0;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pend0 <= 1'b0;
            pend1 <= 1'b0;
            last1 <= 1'b1;   // Favor client 0 first.
        end else begin
            if (grant) begin
                last1 <= sel1;
            end
            if (grant && !sel1) begin
                pend0 <= 1'b0;
            end else if (req0.strobe && !pend0) begin
                pend0 <= 1'b1;
            end
            if (grant && sel1) begin
                pend1 <= 1'b0;
            end else if (req1.strobe && !pend1) begin
                pend1 <= 1'b1;
            end
        end
    end

    // Strobes while busy are dropped.
    always_ff @(posedge clk) begin
        if (req0.strobe && !pend0) begin
            byte0 <= req0.data;
        end
        if (req1.strobe && !pend1) begin
            byte1 <= req1.data;
        end
    end

endmodule

/* hdl/uart_tx.sv */
// UART transmitter sending start, eight data bits LSB first, parity and stop.
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8,
    parameter bit PARITY_ODD   = 1'b0
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       tx_ctrl,
    input  uart_byte_t tx_byte,
    output logic       transmit_ready,
    output logic       tx_serial
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    tx_state_t        state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shreg;
    logic             parity_acc;
    logic             bit_done;

    assign bit_done       = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign transmit_ready = (state == TX_IDLE);

    // ------------------------------------------------------------
    // Control FSM and registered line output
    // ------------------------------------------------------------
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= TX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            tx_serial <= 1'b1;
        end else begin
            if (state == TX_IDLE || state == TX_CLEAN || bit_done) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    tx_serial <= 1'b1;
                    if (tx_ctrl) begin
                        state     <= TX_START;
                        tx_serial <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state     <= TX_DATA;
                        bit_idx   <= '0;
                        tx_serial <= shreg[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state     <= TX_PARITY;
                            tx_serial <= parity_acc ^ shreg[0];
                        end else begin
                            tx_serial <= shreg[1];
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_done) begin
                        state     <= TX_STOP;
                        tx_serial <= 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= TX_CLEAN;
                    end
                end
                TX_CLEAN: begin
                    // One idle-high cycle before ready.
                    state     <= TX_IDLE;
                    tx_serial <= 1'b1;
                end
                default: begin
                    state     <= TX_IDLE;
                    tx_serial <= 1'b1;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Data shifter and running parity
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_ctrl) begin
            shreg      <= tx_byte;
            parity_acc <= PARITY_ODD;
        end else if (state == TX_DATA && bit_done) begin
            shreg      <= shreg >> 1;
            parity_acc <= parity_acc ^ shreg[0];
        end
    end

endmodule

/* hdl/uart_rx.sv */
// UART receiver with mid-bit sampling, parity check and stop-bit check.
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8,
    parameter bit PARITY_ODD   = 1'b0
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       rx_serial,
    output logic       rx_valid,
    output rx_result_t rx_out
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int HALF  = CLKS_PER_BIT / 2;

    rx_state_t        state;
    logic [1:0]       sync_q;
    logic             rx_s;
    logic             rx_prev;
    logic             fall;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shreg;
    logic             parity_acc;
    logic             par_err;
    logic             bit_done;
    logic             half_done;

    assign rx_s      = sync_q[1];
    assign fall      = rx_prev && !rx_s;
    assign bit_done  = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign half_done = (cnt == CNT_W'(HALF - 1));

    // ------------------------------------------------------------
    // Synchronizer and edge detect
    // ------------------------------------------------------------
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[0], rx_serial};
            rx_prev <= rx_s;
        end
    end

    // ------------------------------------------------------------
    // Sampling FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Glitch check at the middle of the start bit.
                    if (half_done) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_done) begin
                        cnt   <= '0;
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        cnt      <= '0;
                        rx_valid <= 1'b1;
                        state    <= RX_IDLE;
                    end
                end
                default: begin
                    cnt   <= '0;
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Data path
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            RX_IDLE: begin
                parity_acc <= PARITY_ODD;
            end
            RX_DATA: begin
                if (bit_done) begin
                    shreg      <= {rx_s, shreg[7:1]};
                    parity_acc <= parity_acc ^ rx_s;
                end
            end
            RX_PARITY: begin
                if (bit_done) begin
                    par_err <= parity_acc ^ rx_s;
                end
            end
            RX_STOP: begin
                // Low stop bit is a framing error.
                if (bit_done) begin
                    rx_out.data       <= shreg;
                    rx_out.parity_err <= par_err;
                    rx_out.frame_err  <= !rx_s;
                end
            end
            default: begin
                parity_acc <= PARITY_ODD;
            end
        endcase
    end

endmodule

/* hdl/uart_link.sv */
// UART link top level joining the client arbiter, transmitter and receiver.
`timescale 1ns/1ps

module uart_link import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8,
    parameter bit PARITY_ODD   = 1'b0
) (
    input  logic        clk,
    input  logic        nRst,
    input  client_req_t req0,
    input  client_req_t req1,
    output logic        busy0,
    output logic        busy1,
    output logic        tx_serial,
    input  logic        rx_serial,
    output logic        rx_valid,
    output rx_result_t  rx_out
);
    logic       tx_ctrl;
    uart_byte_t tx_byte;
    logic       transmit_ready;

    tx_arbiter arb0 (
        .clk            (clk),
        .nRst           (nRst),
        .req0           (req0),
        .req1           (req1),
        .busy0          (busy0),
        .busy1          (busy1),
        .transmit_ready (transmit_ready),
        .tx_ctrl        (tx_ctrl),
        .tx_byte        (tx_byte)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY_ODD   (PARITY_ODD)
    ) tx0 (
        .clk            (clk),
        .nRst           (nRst),
        .tx_ctrl        (tx_ctrl),
        .tx_byte        (tx_byte),
        .transmit_ready (transmit_ready),
        .tx_serial      (tx_serial)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY_ODD   (PARITY_ODD)
    ) rx0 (
        .clk       (clk),
        .nRst      (nRst),
        .rx_serial (rx_serial),
        .rx_valid  (rx_valid),
        .rx_out    (rx_out)
    );

endmodule

/* tb/uart_link_assertions.sv */
// Concurrent protocol checks on the UART link, bound into the top level.
`timescale 1ns/1ps

module uart_link_assertions (
    input logic clk,
    input logic nRst,
    input logic tx_ctrl,
    input logic transmit_ready,
    input logic tx_serial,
    input logic rx_valid
);

    // ------------------------------------------------------------
    // Arbiter to transmitter
    // ------------------------------------------------------------
    ctrl_only_when_ready: assert property (@(posedge clk) disable iff (!nRst)
        tx_ctrl |-> transmit_ready)
        else $error("tx_ctrl pulsed while the transmitter was not ready");

    // Transmitter leaves idle on the edge after the request.
    ready_drops_after_ctrl: assert property (@(posedge clk) disable iff (!nRst)
        tx_ctrl |=> !transmit_ready)
        else $error("transmit_ready stayed high after tx_ctrl");

    // Idle line is high.
    line_high_when_ready: assert property (@(posedge clk) disable iff (!nRst)
        transmit_ready |-> tx_serial)
        else $error("tx_serial low while the transmitter was ready");

    // ------------------------------------------------------------
    // Receiver
    // ------------------------------------------------------------
    valid_one_cycle: assert property (@(posedge clk) disable iff (!nRst)
        rx_valid |=> !rx_valid)
        else $error("rx_valid lasted more than one cycle");

endmodule

bind uart_link uart_link_assertions asrt0 (
    .clk            (clk),
    .nRst           (nRst),
    .tx_ctrl        (tx_ctrl),
    .transmit_ready (transmit_ready),
    .tx_serial      (tx_serial),
    .rx_valid       (rx_valid)
);

/* tb/uart_link_tb.sv */
// Testbench for the UART link with loopback and bit-banged receive frames.
`timescale 1ns/1ps

module uart_link_tb import uart_pkg::*; ();

    localparam int          CLKS_PER_BIT   = 8;
    localparam bit          PARITY_ODD     = 1'b0;
    localparam int          NUM_CLIENTS_TB = 2;
    localparam logic [31:0] LCG_SEED       = 32'h3cd2_1209;
    localparam int          FRAME_CYCLES   = 11 * CLKS_PER_BIT + 1;
    // About 20 frames plus margin.
    localparam int          TIMEOUT_CYCLES = 2500;

    logic        clk;
    logic        nRst;
    client_req_t req0;
    client_req_t req1;
    logic        busy0;
    logic        busy1;
    logic        tx_serial;
    logic        rx_serial;
    logic        rx_valid;
    rx_result_t  rx_out;
    logic        loop_en;
    logic        bang_line;
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    string       test_name;
    rx_result_t  exp_q[$];

    assign rx_serial = loop_en ? tx_serial : bang_line;

    uart_link #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY_ODD   (PARITY_ODD)
    ) dut0 (
        .clk       (clk),
        .nRst      (nRst),
        .req0      (req0),
        .req1      (req1),
        .busy0     (busy0),
        .busy1     (busy1),
        .tx_serial (tx_serial),
        .rx_serial (rx_serial),
        .rx_valid  (rx_valid),
        .rx_out    (rx_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("FAIL %s expected %h actual %h", test, want, got);
        abort_run("Value mismatch");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Waits for the client to be free, then strobes one byte.
    task automatic send_byte(input int client, input uart_byte_t b);
        while ((client == 0) ? busy0 : busy1) begin
            @(negedge clk);
        end
        if (client == 0) begin
            req0 = '{strobe: 1'b1, data: b};
        end else begin
            req1 = '{strobe: 1'b1, data: b};
        end
        exp_q.push_back(rx_result_t'{b, 1'b0, 1'b0});
        @(negedge clk);
        req0.strobe = 1'b0;
        req1.strobe = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Start, data LSB first, parity, stop.
    task automatic bang_frame(input uart_byte_t b, input logic flip_par,
                              input logic stop_bit);
        logic [10:0] bits;
        bits = {stop_bit, (^b) ^ PARITY_ODD ^ flip_par, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            bang_line = bits[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        bang_line = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
    endtask

    // ------------------------------------------------------------
    // Scoreboard and timeout
    // ------------------------------------------------------------
    always @(negedge clk) begin
        rx_result_t want;
        if (nRst && rx_valid) begin
            assert (exp_q.size() != 0)
                else abort_run($sformatf("Unexpected rx_valid in test %s", test_name));
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (rx_out === want)
                    else report_mismatch(test_name, 32'(want), 32'(rx_out));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        uart_byte_t b;
        uart_byte_t b1;
        nRst      = 1'b0;
        req0      = '0;
        req1      = '0;
        loop_en   = 1'b1;
        bang_line = 1'b1;
        lcg_state = LCG_SEED;
        test_name = "reset";
        repeat (4) @(negedge clk);
        nRst = 1'b1;

        @(negedge clk);
        assert (tx_serial === 1'b1) else report_mismatch(test_name, 32'd1, 32'(tx_serial));
        assert (busy0 === 1'b0) else report_mismatch(test_name, 32'd0, 32'(busy0));
        assert (busy1 === 1'b0) else report_mismatch(test_name, 32'd0, 32'(busy1));
        assert (rx_valid === 1'b0) else report_mismatch(test_name, 32'd0, 32'(rx_valid));
        repeat (4 * CLKS_PER_BIT) @(negedge clk);

        test_name = "loopback";
        for (int i = 0; i < 10; i++) begin
            lcg_state = lcg_next(lcg_state);
            send_byte(i % NUM_CLIENTS_TB, lcg_state[23:16]);
        end
        wait_drain();

        // Client 1 was served last each round, so client 0 goes first.
        test_name = "round_robin";
        for (int r = 0; r < 2; r++) begin
            while (busy0 || busy1) begin
                @(negedge clk);
            end
            lcg_state = lcg_next(lcg_state);
            b = lcg_state[23:16];
            lcg_state = lcg_next(lcg_state);
            b1 = lcg_state[23:16];
            req0 = '{strobe: 1'b1, data: b};
            req1 = '{strobe: 1'b1, data: b1};
            exp_q.push_back(rx_result_t'{b, 1'b0, 1'b0});
            exp_q.push_back(rx_result_t'{b1, 1'b0, 1'b0});
            @(negedge clk);
            req0.strobe = 1'b0;
            req1.strobe = 1'b0;
        end
        wait_drain();

        test_name = "back_pressure";
        send_byte(0, 8'hA5);
        send_byte(0, 8'h5A);
        // A5 is in flight, so 5A waits in the slot.
        assert (busy0 === 1'b1) else report_mismatch(test_name, 32'd1, 32'(busy0));
        req0 = '{strobe: 1'b1, data: 8'h3C};
        @(negedge clk);
        req0.strobe = 1'b0;
        wait_drain();
        repeat (2 * FRAME_CYCLES) @(negedge clk);

        loop_en = 1'b0;
        test_name = "parity_error";
        exp_q.push_back(rx_result_t'{8'hC3, 1'b1, 1'b0});
        bang_frame(8'hC3, 1'b1, 1'b1);
        wait_drain();

        test_name = "framing_error";
        exp_q.push_back(rx_result_t'{8'h96, 1'b0, 1'b1});
        bang_frame(8'h96, 1'b0, 1'b0);
        wait_drain();

        test_name = "recovery";
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[23:16];
        exp_q.push_back(rx_result_t'{b, 1'b0, 1'b0});
        bang_frame(b, 1'b0, 1'b1);
        wait_drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* uart_link.f */
hdl/uart_pkg.sv
hdl/tx_arbiter.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_link.sv
tb/uart_link_assertions.sv
tb/uart_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the UART link testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module uart_link_tb \
    -Mdir obj_dir \
    -f uart_link.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vuart_link_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation finished without errors"
exit 0
